// ==== include/rx_dec_defs.svh ====
`ifndef RX_DEC_DEFS_SVH
`define RX_DEC_DEFS_SVH

// APB register map
`define RX_CTRL_ADDR      8'h00
`define RX_OS_CNT_ADDR    8'h04
`define RX_DATA_CNT_ADDR  8'h08
`define RX_ERR_CNT_ADDR   8'h0C

// Encoded block geometry, GEN2 occupies the low 66 bits
`define RX_BLK_W          132
`define RX_G2_HDR_W       2
`define RX_G3_HDR_W       4
`define RX_G2_BYTES       8
`define RX_G3_BYTES       16

// Sync header codes
`define RX_G2_SYNC_OS     2'b01
`define RX_G2_SYNC_DATA   2'b10
`define RX_G3_SYNC_OS     4'b0101
`define RX_G3_SYNC_DATA   4'b1010

// Block counter width
`define RX_CNT_W          16

`endif

// ==== rtl/rx_dec_pkg.sv ====
`include "rx_dec_defs.svh"

package rx_dec_pkg;

    typedef logic [7:0]           byte_t;
    typedef logic [`RX_BLK_W-1:0] enc_blk_t;
    typedef logic [`RX_CNT_W-1:0] cnt_t;
    typedef logic [2:0]           skew_t;
    // Blocks of one class seen in a single take, 0 to 2
    typedef logic [1:0]           evt_cnt_t;

    typedef enum logic {
        GEN2 = 1'b0,
        GEN3 = 1'b1
    } rx_mode_e;

    typedef enum logic [1:0] {
        CLS_OS   = 2'd0,
        CLS_DATA = 2'd1,
        CLS_ERR  = 2'd2
    } blk_class_e;

    typedef enum logic {
        DEC_IDLE = 1'b0,
        DEC_RUN  = 1'b1
    } dec_state_e;

    typedef struct packed {
        logic       valid;
        blk_class_e cls;
        byte_t      data;
    } lane_byte_t;

    // Field order matches the CTRL register bits 4:0
    typedef struct packed {
        skew_t    skew;
        rx_mode_e mode;
        logic     enable;
    } rx_ctrl_t;

    typedef struct packed {
        evt_cnt_t os_inc;
        evt_cnt_t data_inc;
        evt_cnt_t err_inc;
    } class_evt_t;

endpackage

// ==== rtl/apb_regs.sv ====
`timescale 1ns/10ps
`include "rx_dec_defs.svh"

module apb_regs (
    input  logic                   enc_clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  rx_dec_pkg::class_evt_t cls_evt,
    input  logic                   evt_strobe,
    output rx_dec_pkg::rx_ctrl_t   ctrl
);

    logic             access;
    logic             wr_en;
    logic             rd_en;
    logic             addr_hit;
    logic [31:0]      rd_data;
    rx_dec_pkg::cnt_t cnt_os;
    rx_dec_pkg::cnt_t cnt_data;
    rx_dec_pkg::cnt_t cnt_err;

    // Add the per-take increment, sticking at all ones
    function automatic rx_dec_pkg::cnt_t sat_add(rx_dec_pkg::cnt_t c,
                                                 rx_dec_pkg::evt_cnt_t inc);
        logic [`RX_CNT_W:0] sum;
        sum = c + inc;
        return sum[`RX_CNT_W] ? '1 : sum[`RX_CNT_W-1:0];
    endfunction

    // Zero wait states, every access completes in its first access cycle
    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign rd_en  = access & ~pwrite;
    assign pready = access;

    always_comb begin
        addr_hit = 1'b1;
        rd_data  = '0;
        case (paddr)
            `RX_CTRL_ADDR:     rd_data = {27'd0, ctrl};
            `RX_OS_CNT_ADDR:   rd_data = {{(32-`RX_CNT_W){1'b0}}, cnt_os};
            `RX_DATA_CNT_ADDR: rd_data = {{(32-`RX_CNT_W){1'b0}}, cnt_data};
            `RX_ERR_CNT_ADDR:  rd_data = {{(32-`RX_CNT_W){1'b0}}, cnt_err};
            default:           addr_hit = 1'b0;
        endcase
    end

    assign prdata  = rd_en ? rd_data : '0;
    assign pslverr = access & ~addr_hit;

    // CTRL, mode and skew are frozen while the path is enabled
    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            ctrl <= '0;
        end else if (wr_en && paddr == `RX_CTRL_ADDR) begin
            if (ctrl.enable) begin
                ctrl.enable <= pwdata[0];
            end else begin
                ctrl <= rx_dec_pkg::rx_ctrl_t'(pwdata[4:0]);
            end
        end
    end

    // Block counters, a write of any value clears
    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            cnt_os   <= '0;
            cnt_data <= '0;
            cnt_err  <= '0;
        end else begin
            if (wr_en && paddr == `RX_OS_CNT_ADDR) begin
                cnt_os <= '0;
            end else if (evt_strobe) begin
                cnt_os <= sat_add(cnt_os, cls_evt.os_inc);
            end

            if (wr_en && paddr == `RX_DATA_CNT_ADDR) begin
                cnt_data <= '0;
            end else if (evt_strobe) begin
                cnt_data <= sat_add(cnt_data, cls_evt.data_inc);
            end

            if (wr_en && paddr == `RX_ERR_CNT_ADDR) begin
                cnt_err <= '0;
            end else if (evt_strobe) begin
                cnt_err <= sat_add(cnt_err, cls_evt.err_inc);
            end
        end
    end

endmodule

// ==== rtl/block_decoder.sv ====
`timescale 1ns/10ps
`include "rx_dec_defs.svh"

module block_decoder (
    input  logic                   enc_clk,
    input  logic                   rst,
    input  rx_dec_pkg::rx_ctrl_t   ctrl,
    input  rx_dec_pkg::enc_blk_t   lane0_blk,
    input  rx_dec_pkg::enc_blk_t   lane1_blk,
    output logic                   blk_take,
    output rx_dec_pkg::lane_byte_t lane0_out,
    output rx_dec_pkg::lane_byte_t lane1_out,
    output rx_dec_pkg::class_evt_t cls_evt,
    output logic                   evt_strobe
);

    rx_dec_pkg::dec_state_e state;
    logic [3:0]             idx;
    logic [3:0]             last_idx;
    logic                   run_en;
    rx_dec_pkg::enc_blk_t   blk_in [2];
    rx_dec_pkg::blk_class_e new_cls [2];
    rx_dec_pkg::blk_class_e cls_q [2];
    rx_dec_pkg::byte_t      mem [2][`RX_G3_BYTES];
    rx_dec_pkg::lane_byte_t out_q [2];

    function automatic rx_dec_pkg::blk_class_e classify(rx_dec_pkg::enc_blk_t b,
                                                        rx_dec_pkg::rx_mode_e m);
        rx_dec_pkg::blk_class_e c;
        c = rx_dec_pkg::CLS_ERR;
        if (m == rx_dec_pkg::GEN3) begin
            if (b[`RX_G3_HDR_W-1:0] == `RX_G3_SYNC_OS) begin
                c = rx_dec_pkg::CLS_OS;
            end else if (b[`RX_G3_HDR_W-1:0] == `RX_G3_SYNC_DATA) begin
                c = rx_dec_pkg::CLS_DATA;
            end
        end else begin
            if (b[`RX_G2_HDR_W-1:0] == `RX_G2_SYNC_OS) begin
                c = rx_dec_pkg::CLS_OS;
            end else if (b[`RX_G2_HDR_W-1:0] == `RX_G2_SYNC_DATA) begin
                c = rx_dec_pkg::CLS_DATA;
            end
        end
        return c;
    endfunction

    // Payload byte k sits just above the sync header
    function automatic rx_dec_pkg::byte_t blk_byte(rx_dec_pkg::enc_blk_t b,
                                                   rx_dec_pkg::rx_mode_e m, int k);
        if (m == rx_dec_pkg::GEN3) begin
            return b[`RX_G3_HDR_W + 8*k +: 8];
        end
        return b[`RX_G2_HDR_W + 8*k +: 8];
    endfunction

    function automatic rx_dec_pkg::evt_cnt_t count_cls(rx_dec_pkg::blk_class_e a,
                                                       rx_dec_pkg::blk_class_e b,
                                                       rx_dec_pkg::blk_class_e t);
        rx_dec_pkg::evt_cnt_t n;
        n = '0;
        if (a == t) n = n + 2'd1;
        if (b == t) n = n + 2'd1;
        return n;
    endfunction

    assign blk_in[0] = lane0_blk;
    assign blk_in[1] = lane1_blk;

    assign last_idx = (ctrl.mode == rx_dec_pkg::GEN3) ? 4'(`RX_G3_BYTES - 1)
                                                      : 4'(`RX_G2_BYTES - 1);
    assign run_en   = (state == rx_dec_pkg::DEC_RUN) && ctrl.enable;
    // A block period starts whenever the byte index wraps to 0
    assign blk_take = run_en && (idx == 4'd0);

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            new_cls[l] = classify(blk_in[l], ctrl.mode);
        end
    end

    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            state <= rx_dec_pkg::DEC_IDLE;
            idx   <= '0;
        end else begin
            case (state)
                rx_dec_pkg::DEC_IDLE: begin
                    idx <= '0;
                    if (ctrl.enable) state <= rx_dec_pkg::DEC_RUN;
                end
                default: begin
                    if (!ctrl.enable) begin
                        state <= rx_dec_pkg::DEC_IDLE;
                        idx   <= '0;
                    end else begin
                        idx <= (idx == last_idx) ? 4'd0 : idx + 4'd1;
                    end
                end
            endcase
        end
    end

    // Byte 0 goes straight out on the take, the rest come from the array
    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            evt_strobe <= 1'b0;
            for (int l = 0; l < 2; l++) begin
                cls_q[l] <= rx_dec_pkg::CLS_OS;
                out_q[l] <= '0;
            end
        end else begin
            evt_strobe <= blk_take;
            for (int l = 0; l < 2; l++) begin
                out_q[l].valid <= run_en;
                if (blk_take) begin
                    cls_q[l]      <= new_cls[l];
                    out_q[l].cls  <= new_cls[l];
                    out_q[l].data <= blk_byte(blk_in[l], ctrl.mode, 0);
                end else begin
                    out_q[l].cls  <= cls_q[l];
                    out_q[l].data <= mem[l][idx];
                end
            end
        end
    end

    always_ff @(posedge enc_clk) begin
        if (blk_take) begin
            for (int l = 0; l < 2; l++) begin
                for (int k = 0; k < `RX_G3_BYTES; k++) begin
                    mem[l][k] <= blk_byte(blk_in[l], ctrl.mode, k);
                end
            end
        end
    end

    // Class totals of the block pair taken in the previous cycle
    assign cls_evt.os_inc   = count_cls(cls_q[0], cls_q[1], rx_dec_pkg::CLS_OS);
    assign cls_evt.data_inc = count_cls(cls_q[0], cls_q[1], rx_dec_pkg::CLS_DATA);
    assign cls_evt.err_inc  = count_cls(cls_q[0], cls_q[1], rx_dec_pkg::CLS_ERR);

    assign lane0_out = out_q[0];
    assign lane1_out = out_q[1];

endmodule

// ==== rtl/lane_deskew.sv ====
`timescale 1ns/10ps

module lane_deskew (
    input  logic                   enc_clk,
    input  logic                   rst,
    input  rx_dec_pkg::skew_t      skew,
    input  rx_dec_pkg::lane_byte_t lane0_in,
    input  rx_dec_pkg::lane_byte_t lane1_in,
    output rx_dec_pkg::lane_byte_t lane0_out,
    output rx_dec_pkg::lane_byte_t lane1_out
);

    // Tap n of the line is lane 1 delayed by n cycles, tap 0 is the input
    rx_dec_pkg::lane_byte_t dly [8];
    rx_dec_pkg::lane_byte_t tap;

    assign dly[0] = lane1_in;

    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < 8; i++) begin
                dly[i] <= '0;
            end
        end else begin
            for (int i = 1; i < 8; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    assign tap = dly[skew];

    // Matched output stage on both lanes
    always_ff @(posedge enc_clk or negedge rst) begin
        if (!rst) begin
            lane0_out <= '0;
            lane1_out <= '0;
        end else begin
            lane0_out <= lane0_in;
            lane1_out <= tap;
        end
    end

endmodule

// ==== rtl/rx_logical_top.sv ====
`timescale 1ns/10ps

module rx_logical_top (
    input  logic                   enc_clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  rx_dec_pkg::enc_blk_t   lane0_blk,
    input  rx_dec_pkg::enc_blk_t   lane1_blk,
    output logic                   blk_take,
    output rx_dec_pkg::lane_byte_t rx_lane0,
    output rx_dec_pkg::lane_byte_t rx_lane1
);

    rx_dec_pkg::rx_ctrl_t   ctrl;
    rx_dec_pkg::class_evt_t cls_evt;
    logic                   evt_strobe;
    rx_dec_pkg::lane_byte_t dec_lane0;
    rx_dec_pkg::lane_byte_t dec_lane1;

    apb_regs i_apb_regs (
        .enc_clk    (enc_clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .cls_evt    (cls_evt),
        .evt_strobe (evt_strobe),
        .ctrl       (ctrl)
    );

    block_decoder i_block_decoder (
        .enc_clk    (enc_clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .lane0_blk  (lane0_blk),
        .lane1_blk  (lane1_blk),
        .blk_take   (blk_take),
        .lane0_out  (dec_lane0),
        .lane1_out  (dec_lane1),
        .cls_evt    (cls_evt),
        .evt_strobe (evt_strobe)
    );

    // Lane 1 is held back by the software skew setting
    lane_deskew i_lane_deskew (
        .enc_clk   (enc_clk),
        .rst       (rst),
        .skew      (ctrl.skew),
        .lane0_in  (dec_lane0),
        .lane1_in  (dec_lane1),
        .lane0_out (rx_lane0),
        .lane1_out (rx_lane1)
    );

endmodule

// ==== verification/tb_rx_logical.sv ====
`timescale 1ns/10ps
`include "rx_dec_defs.svh"

module tb_rx_logical;

    logic                   enc_clk;
    logic                   rst;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [7:0]             paddr;
    logic [31:0]            pwdata;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    rx_dec_pkg::enc_blk_t   lane0_blk;
    rx_dec_pkg::enc_blk_t   lane1_blk;
    logic                   blk_take;
    rx_dec_pkg::lane_byte_t rx_lane0;
    rx_dec_pkg::lane_byte_t rx_lane1;

    rx_dec_pkg::lane_byte_t exp0 [$];
    rx_dec_pkg::lane_byte_t exp1 [$];
    int                     t0 [$];
    rx_dec_pkg::rx_mode_e   cur_mode;
    int                     cur_skew;
    int                     cyc;
    int                     take_cnt;
    int                     os_cnt;
    int                     data_cnt;
    int                     bad_cnt;
    string                  test_name;

    rx_logical_top i_dut (
        .enc_clk   (enc_clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .lane0_blk (lane0_blk),
        .lane1_blk (lane1_blk),
        .blk_take  (blk_take),
        .rx_lane0  (rx_lane0),
        .rx_lane1  (rx_lane1)
    );

    always #5 enc_clk = ~enc_clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_lane(input rx_dec_pkg::lane_byte_t exp, input rx_dec_pkg::lane_byte_t act);
        if (exp !== act) begin
            stop_run($sformatf("Error %s: expected %h actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_reg(input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            stop_run($sformatf("Error %s: expected %h actual %h", test_name, exp, act));
        end
    endtask

    task automatic check_resp(input logic exp, input logic act);
        if (exp !== act) begin
            stop_run($sformatf("Error %s: expected pslverr %b actual %b", test_name, exp, act));
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            stop_run($sformatf("Error %s: expected %s %b actual %b",
                               test_name, what, exp, act));
        end
    endtask

    task automatic check_delay(input int exp, input int act);
        if (exp != act) begin
            stop_run($sformatf("Error %s: expected lane delay %0d actual %0d",
                               test_name, exp, act));
        end
    endtask

    // Random block with roughly one header in five outside the sync codes
    function automatic rx_dec_pkg::enc_blk_t rand_blk(rx_dec_pkg::rx_mode_e m);
        rx_dec_pkg::enc_blk_t b;
        int                   r;
        logic [3:0]           h;
        b = {$urandom(), $urandom(), $urandom(), $urandom(), 4'($urandom())};
        r = $urandom_range(0, 9);
        if (m == rx_dec_pkg::GEN3) begin
            if (r < 4) h = 4'b0101;
            else if (r < 8) h = 4'b1010;
            else begin
                h = 4'($urandom());
                if (h == 4'b0101 || h == 4'b1010) h = 4'b1111;
            end
            b[3:0] = h;
        end else begin
            if (r < 4) b[1:0] = 2'b01;
            else if (r < 8) b[1:0] = 2'b10;
            else b[1:0] = (r == 8) ? 2'b00 : 2'b11;
        end
        return b;
    endfunction

    // Reference decode of one block into the lane queue
    task automatic model_block(input rx_dec_pkg::enc_blk_t b, input int lane);
        rx_dec_pkg::lane_byte_t e;
        int                     nbytes;
        int                     lsb;
        e.valid = 1'b1;
        e.cls   = rx_dec_pkg::CLS_ERR;
        if (cur_mode == rx_dec_pkg::GEN3) begin
            nbytes = 16;
            lsb    = 4;
            if (b[3:0] == 4'b0101) e.cls = rx_dec_pkg::CLS_OS;
            if (b[3:0] == 4'b1010) e.cls = rx_dec_pkg::CLS_DATA;
        end else begin
            nbytes = 8;
            lsb    = 2;
            if (b[1:0] == 2'b01) e.cls = rx_dec_pkg::CLS_OS;
            if (b[1:0] == 2'b10) e.cls = rx_dec_pkg::CLS_DATA;
        end
        case (e.cls)
            rx_dec_pkg::CLS_OS:   os_cnt++;
            rx_dec_pkg::CLS_DATA: data_cnt++;
            default:              bad_cnt++;
        endcase
        for (int k = 0; k < nbytes; k++) begin
            e.data = b[8*k + lsb +: 8];
            if (lane == 0) exp0.push_back(e);
            else exp1.push_back(e);
        end
    endtask

    // New random blocks every cycle so that each take sees fresh ones
    always @(posedge enc_clk) begin
        if (rst) begin
            lane0_blk <= rand_blk(cur_mode);
            lane1_blk <= rand_blk(cur_mode);
        end
    end

    always @(negedge enc_clk) begin
        int t;
        cyc++;
        if (rst && blk_take) begin
            take_cnt++;
            model_block(lane0_blk, 0);
            model_block(lane1_blk, 1);
        end
        if (rx_lane0.valid) begin
            if (exp0.size() == 0) begin
                stop_run("Lane 0 delivered a byte that the model did not expect");
            end else begin
                check_lane(exp0.pop_front(), rx_lane0);
                t0.push_back(cyc);
            end
        end
        if (rx_lane1.valid) begin
            if (exp1.size() == 0 || t0.size() == 0) begin
                stop_run("Lane 1 delivered a byte that the model did not expect");
            end else begin
                check_lane(exp1.pop_front(), rx_lane1);
                t = t0.pop_front();
                check_delay(cur_skew, cyc - t);
            end
        end
    end

    task automatic apb_xfer(input logic [7:0] a, input logic w, input logic [31:0] d,
                            output logic [31:0] r, output logic e);
        @(posedge enc_clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= w;
        paddr   <= a;
        pwdata  <= d;
        @(posedge enc_clk);
        penable <= 1'b1;
        // The slave has no wait states
        @(negedge enc_clk);
        check_flag("pready", 1'b1, pready);
        r = prdata;
        e = pslverr;
        @(posedge enc_clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_expect(input logic [7:0] a, input logic [31:0] exp);
        logic [31:0] r;
        logic        e;
        apb_xfer(a, 1'b0, '0, r, e);
        check_resp(1'b0, e);
        check_reg(exp, r);
    endtask

    task automatic reg_write(input logic [7:0] a, input logic [31:0] d);
        logic [31:0] r;
        logic        e;
        apb_xfer(a, 1'b1, d, r, e);
        check_resp(1'b0, e);
    endtask

    task automatic run_blocks(input int n);
        int target;
        int wait_cyc;
        target   = take_cnt + n;
        wait_cyc = 0;
        while (take_cnt < target) begin
            @(negedge enc_clk);
            wait_cyc++;
            if (wait_cyc > n * 20 + 20) stop_run("Blocks stopped being taken while enabled");
        end
    endtask

    // Disable, then let the deskew line empty before the queues are dropped
    // Lane 0 drops valid two cycles after enable clears, lane 1 skew cycles later
    task automatic stop_and_drain();
        int wait_cyc;
        reg_write(`RX_CTRL_ADDR, {27'd0, 3'(cur_skew), cur_mode, 1'b0});
        @(negedge enc_clk);
        wait_cyc = 0;
        if (blk_take) stop_run("A block was taken after enable was cleared");
        while (rx_lane0.valid || rx_lane1.valid) begin
            if (rx_lane0.valid && wait_cyc >= 2) begin
                stop_run("Lane 0 output stayed valid too long after enable was cleared");
            end
            if (wait_cyc >= 2 + cur_skew) begin
                stop_run("Lane 1 output stayed valid too long after enable was cleared");
            end
            @(negedge enc_clk);
            wait_cyc++;
            if (blk_take) stop_run("A block was taken after enable was cleared");
        end
        exp0.delete();
        exp1.delete();
        t0.delete();
    endtask

    task automatic check_counters();
        read_expect(`RX_OS_CNT_ADDR, 32'(os_cnt));
        read_expect(`RX_DATA_CNT_ADDR, 32'(data_cnt));
        read_expect(`RX_ERR_CNT_ADDR, 32'(bad_cnt));
    endtask

    initial begin
        logic [31:0] r;
        logic        e;
        void'($urandom(32'h3b8777fb));
        enc_clk   = 1'b0;
        rst       = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        lane0_blk = '0;
        lane1_blk = '0;
        cur_mode  = rx_dec_pkg::GEN2;
        cur_skew  = 0;
        cyc       = 0;
        take_cnt  = 0;
        os_cnt    = 0;
        data_cnt  = 0;
        bad_cnt   = 0;
        repeat (3) @(posedge enc_clk);
        rst <= 1'b1;

        test_name = "reset";
        read_expect(`RX_CTRL_ADDR, '0);
        check_counters();
        repeat (10) begin
            @(negedge enc_clk);
            check_flag("lane 0 valid", 1'b0, rx_lane0.valid);
            check_flag("lane 1 valid", 1'b0, rx_lane1.valid);
        end

        test_name = "gen2_skew0";
        reg_write(`RX_CTRL_ADDR, {27'd0, 3'd0, rx_dec_pkg::GEN2, 1'b1});
        run_blocks(40);
        stop_and_drain();

        test_name = "counters";
        check_counters();
        reg_write(`RX_OS_CNT_ADDR, 32'hffff_ffff);
        reg_write(`RX_DATA_CNT_ADDR, 32'h0);
        reg_write(`RX_ERR_CNT_ADDR, 32'h1234);
        os_cnt   = 0;
        data_cnt = 0;
        bad_cnt  = 0;
        check_counters();

        test_name = "unmapped";
        apb_xfer(8'h10, 1'b0, '0, r, e);
        check_resp(1'b1, e);

        test_name = "gen3_skew";
        cur_mode  = rx_dec_pkg::GEN3;
        cur_skew  = $urandom_range(1, 7);
        reg_write(`RX_CTRL_ADDR, {27'd0, 3'(cur_skew), rx_dec_pkg::GEN3, 1'b1});
        read_expect(`RX_CTRL_ADDR, {27'd0, 3'(cur_skew), rx_dec_pkg::GEN3, 1'b1});
        run_blocks(30);
        stop_and_drain();
        test_name = "gen3_counters";
        check_counters();

        test_name = "gen2_reenable";
        cur_mode  = rx_dec_pkg::GEN2;
        cur_skew  = $urandom_range(0, 7);
        reg_write(`RX_CTRL_ADDR, {27'd0, 3'(cur_skew), rx_dec_pkg::GEN2, 1'b1});
        run_blocks(25);
        stop_and_drain();
        check_counters();

        $display("test passed");
        $finish;
    end

    initial begin
        #2000000;
        $display("Simulation ran past its time limit");
        $display("test failed");
        $fatal(1);
    end

endmodule

// ==== tb.f ====
+incdir+include
rtl/rx_dec_pkg.sv
rtl/apb_regs.sv
rtl/block_decoder.sv
rtl/lane_deskew.sv
rtl/rx_logical_top.sv
verification/tb_rx_logical.sv

// ==== Makefile ====
TOP := tb_rx_logical

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wall -f tb.f --top-module $(TOP)

obj_dir/V$(TOP): tb.f include/rx_dec_defs.svh rtl/*.sv verification/*.sv
	verilator --binary --timing -f tb.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "test failed" sim.log; then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "test passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
